// File: sources.f
common/frontend_pkg.sv
logic/bootrom.sv
logic/frontend_csr.sv
icache/icache.sv
icache_interface/icache_interface.sv
logic/fetch_frontend.sv
test/tb_clock.sv
test/tb_line_memory.sv
test/tb_fetch_frontend.sv

// File: Makefile
# Verilator build and run for the fetch front end testbench

TOP := tb_fetch_frontend

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_fetch_frontend.sv
// Fetch front end testbench driving a table of CSR, fetch, kill and flush operations
module tb_fetch_frontend;
    import frontend_pkg::*;

    localparam int BROM_WORDS   = 4096;
    localparam int ICACHE_LINES = 16;
    localparam int KILL_QUIET   = 10;      // Silent cycles after a kill

    typedef enum logic [2:0] {OP_CSR_WR, OP_CSR_RD, OP_FETCH, OP_KILL, OP_FLUSH} op_kind_t;

    typedef struct packed {
        op_kind_t    kind;
        csr_addr_t   csr_addr;
        addr_t       value;                // PC or CSR write data
        logic [31:0] exp_data;
        logic        exp_fault;
        logic        exp_miss;             // One refill expected
    } test_row_t;

    logic             clk;
    logic             rstn;
    req_cpu_icache_t  req_fetch;
    logic             req_ready;
    resp_icache_cpu_t resp_fetch;
    mem_req_t         mem_req;
    mem_resp_t        mem_resp;
    logic             csr_we;
    csr_addr_t        csr_addr;
    logic [1:0]       csr_wdata;
    logic [1:0]       csr_rdata;
    int               mem_req_count;

    test_row_t rows[$];
    string     names[$];
    string     cur_name;
    int        row_errors;
    int        pass_count;
    int        fail_count;
    int        cycle_count = 0;
    int        cycle_limit;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(16)) u_clock (.clk_o(clk), .rstn_o(rstn));

    tb_line_memory u_line_memory (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .mem_req_i   (mem_req),
        .mem_resp_o  (mem_resp),
        .req_count_o (mem_req_count)
    );

    fetch_frontend #(
        .BROM_WORDS   (BROM_WORDS),
        .ICACHE_LINES (ICACHE_LINES)
    ) u_fetch_frontend (
        .clk_i             (clk),
        .rstn_i            (rstn),
        .req_fetch_i       (req_fetch),
        .req_fetch_ready_o (req_ready),
        .resp_fetch_o      (resp_fetch),
        .mem_req_o         (mem_req),
        .mem_resp_i        (mem_resp),
        .csr_we_i          (csr_we),
        .csr_addr_i        (csr_addr),
        .csr_wdata_i       (csr_wdata),
        .csr_rdata_o       (csr_rdata)
    );

    // ROM word is a fixed base plus the word index
    function automatic logic [31:0] rom_word(addr_t pc);
        return 32'hB000_0000 + 32'(pc >> 2);
    endfunction

    // Refilled word equals its own byte address
    function automatic logic [31:0] line_word(addr_t pc);
        return {pc[31:2], 2'b00};
    endfunction

    task automatic add_row(string name, op_kind_t kind, csr_addr_t ca, addr_t value,
                           logic [31:0] exp_data, logic exp_fault, logic exp_miss);
        rows.push_back(test_row_t'{kind, ca, value, exp_data, exp_fault, exp_miss});
        names.push_back(name);
    endtask

    task automatic check_equal(string what, logic [39:0] expected, logic [39:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic check_true(logic ok, string what);
        assert (ok === 1'b1) else begin
            $display("FAILED %s: %s", cur_name, what);
            row_errors++;
        end
    endtask

    // Hold the request until ready and return on the falling edge after acceptance
    task automatic send_fetch(addr_t pc);
        @(negedge clk);
        req_fetch.valid = 1'b1;
        req_fetch.vaddr = pc;
        #1;
        while (req_ready !== 1'b1) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);                    // Taken here
        @(negedge clk);
        req_fetch.valid = 1'b0;
    endtask

    task automatic run_fetch(test_row_t row);
        int start_count;
        int waited;
        start_count = mem_req_count;
        waited      = 0;
        send_fetch(row.value);
        while (resp_fetch.valid !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        #1;                                // Memory model counts requests on this edge too
        if (!row.exp_miss) begin
            check_true(waited == 0, "response did not arrive 1 cycle after acceptance");
        end
        check_equal("data", 40'(row.exp_data), 40'(resp_fetch.data));
        check_equal("fault", 40'(row.exp_fault), 40'(resp_fetch.instr_page_fault));
        check_equal("mem_req count", 40'(row.exp_miss), 40'(mem_req_count - start_count));
    endtask

    task automatic run_kill(test_row_t row);
        int   start_count;
        logic seen;
        start_count = mem_req_count;
        send_fetch(row.value);
        req_fetch.inval_fetch = 1'b1;      // Kill while the miss is pending
        seen = resp_fetch.valid;
        @(negedge clk);
        req_fetch.inval_fetch = 1'b0;
        seen = seen | resp_fetch.valid;
        #1;
        while (req_ready !== 1'b1) begin
            @(negedge clk);
            seen = seen | resp_fetch.valid;
            #1;
        end
        repeat (KILL_QUIET) begin
            @(negedge clk);
            seen = seen | resp_fetch.valid;
        end
        check_true(!seen, "a response came back for a killed fetch");
        check_equal("mem_req count", 40'(row.exp_miss), 40'(mem_req_count - start_count));
    endtask

    // Timeout guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        req_fetch  = '0;
        csr_we     = 1'b0;
        csr_addr   = CSR_CTRL;
        csr_wdata  = 2'b00;
        pass_count = 0;
        fail_count = 0;

        add_row("rom_fetch_low", OP_FETCH, CSR_CTRL, 40'h100, rom_word(40'h100), 0, 0);
        add_row("rom_fetch_last", OP_FETCH, CSR_CTRL, 40'h3ffc, rom_word(40'h3ffc), 0, 0);
        add_row("ctrl_reads_zero", OP_CSR_RD, CSR_CTRL, 40'h0, 32'h0, 0, 0);
        add_row("set_spi_boot", OP_CSR_WR, CSR_CTRL, 40'h2, 32'h0, 0, 0);
        add_row("ctrl_reads_spi", OP_CSR_RD, CSR_CTRL, 40'h0, 32'h2, 0, 0);
        add_row("cache_miss", OP_FETCH, CSR_CTRL, 40'h200, line_word(40'h200), 0, 1);
        add_row("cache_hit_word2", OP_FETCH, CSR_CTRL, 40'h208, line_word(40'h208), 0, 0);
        add_row("cache_hit_word3", OP_FETCH, CSR_CTRL, 40'h20c, line_word(40'h20c), 0, 0);
        add_row("flush_cache", OP_FLUSH, CSR_CTRL, 40'h0, 32'h0, 0, 0);
        add_row("miss_after_flush", OP_FETCH, CSR_CTRL, 40'h204, line_word(40'h204), 0, 1);
        add_row("hit_after_refill", OP_FETCH, CSR_CTRL, 40'h200, line_word(40'h200), 0, 0);
        add_row("set_translation", OP_CSR_WR, CSR_CTRL, 40'h1, 32'h0, 0, 0);
        add_row("ctrl_reads_trans", OP_CSR_RD, CSR_CTRL, 40'h0, 32'h1, 0, 0);
        add_row("cache_route_low_pc", OP_FETCH, CSR_CTRL, 40'h100, line_word(40'h100), 0, 1);
        add_row("page_fault", OP_FETCH, CSR_CTRL, 40'h80_0000_1000, 32'h0, 1, 0);
        add_row("status_after_fault", OP_CSR_RD, CSR_STATUS, 40'h0, 32'h1, 0, 0);
        add_row("clear_status", OP_CSR_WR, CSR_STATUS, 40'h0, 32'h0, 0, 0);
        add_row("status_reads_zero", OP_CSR_RD, CSR_STATUS, 40'h0, 32'h0, 0, 0);
        add_row("kill_pending_miss", OP_KILL, CSR_CTRL, 40'h400, 32'h0, 0, 1);
        add_row("hit_after_kill", OP_FETCH, CSR_CTRL, 40'h408, line_word(40'h408), 0, 0);
        add_row("clear_ctrl", OP_CSR_WR, CSR_CTRL, 40'h0, 32'h0, 0, 0);
        add_row("rom_route_again", OP_FETCH, CSR_CTRL, 40'h100, rom_word(40'h100), 0, 0);
        add_row("high_pc_miss", OP_FETCH, CSR_CTRL, 40'h1_0040, line_word(40'h1_0040), 0, 1);
        add_row("high_pc_hit", OP_FETCH, CSR_CTRL, 40'h1_004c, line_word(40'h1_004c), 0, 0);
        cycle_limit = rows.size() * 20 + 100;

        wait (rstn === 1'b1);
        for (int i = 0; i < rows.size(); i++) begin
            cur_name   = names[i];
            row_errors = 0;
            case (rows[i].kind)
                OP_CSR_WR: begin
                    @(negedge clk);
                    csr_we    = 1'b1;
                    csr_addr  = rows[i].csr_addr;
                    csr_wdata = rows[i].value[1:0];
                    @(negedge clk);
                    csr_we    = 1'b0;
                end
                OP_CSR_RD: begin
                    @(negedge clk);
                    csr_addr = rows[i].csr_addr;
                    #1;
                    check_equal("csr_rdata", 40'(rows[i].exp_data), 40'(csr_rdata));
                end
                OP_FLUSH: begin
                    @(negedge clk);
                    req_fetch.invalidate_icache = 1'b1;
                    @(negedge clk);
                    req_fetch.invalidate_icache = 1'b0;
                    #1;
                    check_true(req_ready, "cache not ready one cycle after invalidate");
                end
                OP_KILL:  run_kill(rows[i]);
                default:  run_fetch(rows[i]);
            endcase
            if (row_errors == 0) begin
                pass_count++;
                $display("test %-20s ok", cur_name);
            end else begin
                fail_count++;
                $display("test %-20s failed with %0d errors", cur_name, row_errors);
            end
        end

        $display("Tests: %0d run, %0d passed, %0d failed", rows.size(), pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: test/tb_line_memory.sv
// Behavioral refill memory: answers each line request after a random 1 to 6 cycle delay
module tb_line_memory (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  frontend_pkg::mem_req_t  mem_req_i,
    output frontend_pkg::mem_resp_t mem_resp_o,
    output int                      req_count_o  // mem_req pulses seen
);
    import frontend_pkg::*;

    integer     seed;
    logic       busy;
    int         wait_cycles;
    line_addr_t line_addr;

    // Every word holds the low 32 bits of its own byte address
    function automatic icache_line_t make_line(line_addr_t la);
        icache_line_t line;
        addr_t        base;
        base = {la, 4'h0};
        for (int k = 0; k < 4; k++) begin
            line[k*32 +: 32] = base[31:0] + 32'(k * 4);
        end
        return line;
    endfunction

    // Single process, all outputs move on the falling edge
    initial begin
        seed        = 32'hcc27_35af;
        mem_resp_o  = '0;
        req_count_o = 0;
        busy        = 1'b0;
        wait_cycles = 0;
        line_addr   = '0;
        forever begin
            @(negedge clk_i);
            mem_resp_o.valid = 1'b0;           // Response is a one-cycle pulse
            if (!rstn_i) begin
                busy = 1'b0;
            end else if (busy) begin
                wait_cycles--;
                if (wait_cycles == 0) begin
                    mem_resp_o.valid = 1'b1;
                    mem_resp_o.line  = make_line(line_addr);
                    busy             = 1'b0;
                end
            end else if (mem_req_i.valid) begin
                busy        = 1'b1;
                line_addr   = mem_req_i.line_addr;
                wait_cycles = 1 + int'($unsigned($random(seed)) % 6); // 1..6 cycles
                req_count_o++;
            end
        end
    end

endmodule

// File: test/tb_clock.sv
// Testbench clock and reset source, free-running clock with active-low reset held at start
module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;                          // In reset from time zero
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;                          // Released between sampling edges
    end

endmodule

// File: logic/fetch_frontend.sv
// Fetch front end top: CSR block, icache interface, instruction cache and boot ROM
module fetch_frontend #(
    parameter int BROM_WORDS   = 4096,
    parameter int ICACHE_LINES = 16
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  frontend_pkg::req_cpu_icache_t  req_fetch_i,
    output logic                           req_fetch_ready_o,
    output frontend_pkg::resp_icache_cpu_t resp_fetch_o,
    output frontend_pkg::mem_req_t         mem_req_o,
    input  frontend_pkg::mem_resp_t        mem_resp_i,
    input  logic                           csr_we_i,
    input  frontend_pkg::csr_addr_t        csr_addr_i,
    input  logic [1:0]                     csr_wdata_i,
    output logic [1:0]                     csr_rdata_o
);
    import frontend_pkg::*;

    frontend_cfg_t cfg;

    // Interface to cache
    logic          ic_req_valid;
    logic          ic_req_ready;
    icache_vpn_t   ic_req_vpn;
    icache_idx_t   ic_req_idx;
    logic          ic_req_kill;
    logic          ic_invalidate;
    logic          ic_resp_valid;
    icache_line_t  ic_resp_line;
    addr_t         ic_resp_vaddr;
    logic          ic_tlb_xcpt;

    // Interface to boot ROM
    logic          brom_req_valid;
    logic [23:0]   brom_req_addr;
    logic          brom_resp_valid;
    logic [31:0]   brom_resp_data;

    frontend_csr u_csr (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .fault_i     (resp_fetch_o.instr_page_fault),
        .cfg_o       (cfg),
        .csr_rdata_o (csr_rdata_o)
    );

    icache_interface #(
        .BROM_WORDS (BROM_WORDS)
    ) u_icache_interface (
        .clk_i                   (clk_i),
        .rstn_i                  (rstn_i),
        .req_fetch_icache_i      (req_fetch_i),
        .cfg_i                   (cfg),
        .icache_resp_datablock_i (ic_resp_line),
        .icache_resp_vaddr_i     (ic_resp_vaddr),
        .icache_resp_valid_i     (ic_resp_valid),
        .icache_req_ready_i      (ic_req_ready),
        .tlb_resp_xcp_if_i       (ic_tlb_xcpt),
        .icache_invalidate_o     (ic_invalidate),
        .icache_req_bits_idx_o   (ic_req_idx),
        .icache_req_bits_vpn_o   (ic_req_vpn),
        .icache_req_kill_o       (ic_req_kill),
        .icache_req_valid_o      (ic_req_valid),
        .brom_ready_i            (rstn_i),          // ROM ready once out of reset
        .brom_resp_data_i        (brom_resp_data),
        .brom_resp_valid_i       (brom_resp_valid),
        .brom_req_address_o      (brom_req_addr),
        .brom_req_valid_o        (brom_req_valid),
        .resp_icache_fetch_o     (resp_fetch_o),
        .req_fetch_ready_o       (req_fetch_ready_o)
    );

    icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) u_icache (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cfg_i        (cfg),
        .req_valid_i  (ic_req_valid),
        .req_vpn_i    (ic_req_vpn),
        .req_idx_i    (ic_req_idx),
        .req_kill_i   (ic_req_kill),
        .invalidate_i (ic_invalidate),
        .mem_resp_i   (mem_resp_i),
        .req_ready_o  (ic_req_ready),
        .resp_valid_o (ic_resp_valid),
        .resp_line_o  (ic_resp_line),
        .resp_vaddr_o (ic_resp_vaddr),
        .tlb_xcpt_o   (ic_tlb_xcpt),
        .mem_req_o    (mem_req_o)
    );

    bootrom #(
        .BROM_WORDS (BROM_WORDS)
    ) u_bootrom (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (brom_req_valid),
        .req_addr_i   (brom_req_addr),
        .resp_valid_o (brom_resp_valid),
        .resp_data_o  (brom_resp_data)
    );

endmodule

// File: icache_interface/icache_interface.sv
// Icache interface: steers fetches to the cache or boot ROM and builds the 32-bit response
module icache_interface #(
    parameter int BROM_WORDS = 4096
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  frontend_pkg::req_cpu_icache_t  req_fetch_icache_i,
    input  frontend_pkg::frontend_cfg_t    cfg_i,
    // Cache side
    input  frontend_pkg::icache_line_t     icache_resp_datablock_i,
    input  frontend_pkg::addr_t            icache_resp_vaddr_i,
    input  logic                           icache_resp_valid_i,
    input  logic                           icache_req_ready_i,
    input  logic                           tlb_resp_xcp_if_i,
    output logic                           icache_invalidate_o,
    output frontend_pkg::icache_idx_t      icache_req_bits_idx_o,
    output frontend_pkg::icache_vpn_t      icache_req_bits_vpn_o,
    output logic                           icache_req_kill_o,
    output logic                           icache_req_valid_o,
    // Boot ROM side
    input  logic                           brom_ready_i,
    input  logic [31:0]                    brom_resp_data_i,
    input  logic                           brom_resp_valid_i,
    output logic [23:0]                    brom_req_address_o,
    output logic                           brom_req_valid_o,
    // Back to fetch
    output frontend_pkg::resp_icache_cpu_t resp_icache_fetch_o,
    output logic                           req_fetch_ready_o
);
    import frontend_pkg::*;

    localparam addr_t BROM_BYTES = addr_t'(BROM_WORDS) << 2; // ROM size in bytes

    logic        is_brom_access;  // This request targets the ROM
    logic        do_icache_req;
    logic        do_brom_req;
    addr_t       old_pc_q;        // PC of last accepted fetch
    logic        old_brom_q;      // Last accepted fetch went to ROM
    logic        cache_resp_ok;
    logic [31:0] cache_word;

    // ROM only while running physical, non-SPI boot code
    assign is_brom_access = ~cfg_i.en_translation & ~cfg_i.spi_boot &
                            (req_fetch_icache_i.vaddr < BROM_BYTES);

    assign do_icache_req = req_fetch_icache_i.valid & ~req_fetch_icache_i.invalidate_buffer &
                           ~is_brom_access & icache_req_ready_i;
    assign do_brom_req   = req_fetch_icache_i.valid & is_brom_access & brom_ready_i;

    assign icache_req_valid_o    = do_icache_req;
    assign icache_req_bits_vpn_o = req_fetch_icache_i.vaddr[ADDR_SIZE-1:12];
    assign icache_req_bits_idx_o = req_fetch_icache_i.vaddr[11:0];
    assign icache_req_kill_o     = req_fetch_icache_i.inval_fetch;
    assign icache_invalidate_o   = req_fetch_icache_i.invalidate_icache;

    assign brom_req_valid_o   = do_brom_req;
    assign brom_req_address_o = req_fetch_icache_i.vaddr[23:0]; // Byte address

    // Ready follows whichever target this PC maps to
    assign req_fetch_ready_o = is_brom_access ? brom_ready_i : icache_req_ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            old_pc_q   <= '0;
            old_brom_q <= 1'b0;
        end else if (do_icache_req | do_brom_req) begin
            old_pc_q   <= req_fetch_icache_i.vaddr;
            old_brom_q <= do_brom_req;
        end
    end

    // Only accept a cache response for the line we last asked for
    assign cache_resp_ok = icache_resp_valid_i &
                           (icache_resp_vaddr_i[ADDR_SIZE-1:4] == old_pc_q[ADDR_SIZE-1:4]);

    // Word select from bits 3..2
    assign cache_word = icache_resp_datablock_i[old_pc_q[3:2]*32 +: 32];

    always_comb begin
        resp_icache_fetch_o.valid            = old_brom_q ? brom_resp_valid_i : cache_resp_ok;
        resp_icache_fetch_o.instr_page_fault = ~old_brom_q & cache_resp_ok & tlb_resp_xcp_if_i;
        if (resp_icache_fetch_o.instr_page_fault) begin
            resp_icache_fetch_o.data = 32'h0; // Faulting fetch carries no data
        end else if (old_brom_q) begin
            resp_icache_fetch_o.data = brom_resp_data_i;
        end else begin
            resp_icache_fetch_o.data = cache_word;
        end
    end

endmodule

// File: icache/icache.sv
// Direct-mapped instruction cache with line refill, kill, flush and canonical-address fault
module icache #(
    parameter int ICACHE_LINES = 16
) (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  frontend_pkg::frontend_cfg_t cfg_i,
    input  logic                        req_valid_i,
    input  frontend_pkg::icache_vpn_t   req_vpn_i,
    input  frontend_pkg::icache_idx_t   req_idx_i,
    input  logic                        req_kill_i,
    input  logic                        invalidate_i,
    input  frontend_pkg::mem_resp_t     mem_resp_i,
    output logic                        req_ready_o,
    output logic                        resp_valid_o,
    output frontend_pkg::icache_line_t  resp_line_o,
    output frontend_pkg::addr_t         resp_vaddr_o,
    output logic                        tlb_xcpt_o,
    output frontend_pkg::mem_req_t      mem_req_o
);
    import frontend_pkg::*;

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = LINE_ADDR_SIZE - IDX_W;

    icache_state_t     state_q, state_d;

    // Storage arrays
    logic [TAG_W-1:0]        tag_q  [ICACHE_LINES];
    icache_line_t            data_q [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] valid_q;

    addr_t             req_vaddr;
    line_addr_t        req_line;
    logic [IDX_W-1:0]  req_set;
    logic [TAG_W-1:0]  req_tag;
    logic              req_fire;
    logic              req_hit;
    logic              req_fault;

    addr_t             pend_vaddr_q; // Missing fetch address
    line_addr_t        pend_line;
    logic              killed_q;     // Pending response dropped
    logic              refill_done;

    logic              resp_valid_q;
    logic              xcpt_q;
    icache_line_t      resp_line_q;
    addr_t             resp_vaddr_q;

    assign req_vaddr = {req_vpn_i, req_idx_i};
    assign req_line  = req_vaddr[ADDR_SIZE-1:4];
    assign req_set   = req_line[IDX_W-1:0];
    assign req_tag   = req_line[LINE_ADDR_SIZE-1:IDX_W];
    assign pend_line = pend_vaddr_q[ADDR_SIZE-1:4];

    // Flush cycle blocks new requests
    assign req_ready_o = (state_q == ST_IDLE) & ~invalidate_i;
    assign req_fire    = req_valid_i & req_ready_o;
    assign req_hit     = valid_q[req_set] & (tag_q[req_set] == req_tag);
    // Non-canonical PC, stands in for the TLB
    assign req_fault   = cfg_i.en_translation & (req_vaddr[ADDR_SIZE-1] ^ req_vaddr[ADDR_SIZE-2]);
    assign refill_done = (state_q == ST_REFILL_WAIT) & mem_resp_i.valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_fire & ~req_fault & ~req_hit) begin
                    state_d = ST_MISS;
                end
            end
            ST_MISS:        state_d = ST_REFILL_WAIT; // One request pulse
            ST_REFILL_WAIT: begin
                if (mem_resp_i.valid) begin
                    state_d = ST_IDLE;
                end
            end
            default:        state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= ST_IDLE;
            valid_q      <= '0;
            killed_q     <= 1'b0;
            resp_valid_q <= 1'b0;
            xcpt_q       <= 1'b0;
        end else begin
            state_q <= state_d;
            if (invalidate_i) begin
                valid_q <= '0; // Whole-cache flush
            end
            if (refill_done) begin
                valid_q[pend_line[IDX_W-1:0]] <= 1'b1;
            end
            if (req_fire) begin
                killed_q <= 1'b0;
            end else if ((state_q != ST_IDLE) & req_kill_i) begin
                killed_q <= 1'b1;
            end
            resp_valid_q <= (req_fire & (req_fault | req_hit)) |
                            (refill_done & ~killed_q & ~req_kill_i);
            xcpt_q       <= req_fire & req_fault;
        end
    end

    // Arrays and response payload
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            pend_vaddr_q <= req_vaddr;
            resp_vaddr_q <= req_vaddr;
            resp_line_q  <= req_fault ? '0 : data_q[req_set];
        end
        if (refill_done) begin
            tag_q[pend_line[IDX_W-1:0]]  <= pend_line[LINE_ADDR_SIZE-1:IDX_W];
            data_q[pend_line[IDX_W-1:0]] <= mem_resp_i.line;
            resp_line_q                  <= mem_resp_i.line; // Forward refilled line
            resp_vaddr_q                 <= pend_vaddr_q;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_line_o  = resp_line_q;
    assign resp_vaddr_o = resp_vaddr_q;
    assign tlb_xcpt_o   = xcpt_q;

    assign mem_req_o.valid     = (state_q == ST_MISS);
    assign mem_req_o.line_addr = pend_line;

endmodule

// File: logic/frontend_csr.sv
// Front end config registers: translation enable, SPI boot and sticky fault status
module frontend_csr (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        csr_we_i,
    input  frontend_pkg::csr_addr_t     csr_addr_i,
    input  logic [1:0]                  csr_wdata_i,
    input  logic                        fault_i,     // Page fault seen on response
    output frontend_pkg::frontend_cfg_t cfg_o,
    output logic [1:0]                  csr_rdata_o
);
    import frontend_pkg::*;

    frontend_cfg_t cfg_q;
    logic          fault_seen_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q        <= '0; // ROM boot after reset
            fault_seen_q <= 1'b0;
        end else begin
            if (csr_we_i && csr_addr_i == CSR_CTRL) begin
                cfg_q.en_translation <= csr_wdata_i[0];
                cfg_q.spi_boot       <= csr_wdata_i[1];
            end
            // New fault wins over a clearing write
            if (fault_i) begin
                fault_seen_q <= 1'b1;
            end else if (csr_we_i && csr_addr_i == CSR_STATUS) begin
                fault_seen_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (csr_addr_i)
            CSR_CTRL:   csr_rdata_o = {cfg_q.spi_boot, cfg_q.en_translation};
            CSR_STATUS: csr_rdata_o = {1'b0, fault_seen_q};
            default:    csr_rdata_o = 2'b00;
        endcase
    end

    assign cfg_o = cfg_q;

endmodule

// File: logic/bootrom.sv
// Boot ROM: fixed word pattern with a one-cycle registered read
module bootrom #(
    parameter int BROM_WORDS = 4096
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        req_valid_i,
    input  logic [23:0] req_addr_i,   // Byte address
    output logic        resp_valid_o,
    output logic [31:0] resp_data_o
);

    logic [21:0] word_idx;

    assign word_idx = req_addr_i[23:2];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= req_valid_i; // One cycle read
        end
    end

    // Past the end reads as zero
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            resp_data_o <= (word_idx < BROM_WORDS) ? 32'hB000_0000 + 32'(word_idx) : 32'h0;
        end
    end

endmodule

// File: common/frontend_pkg.sv
// Fetch front end package: address, line, request and response types, FSM and CSR encodings
package frontend_pkg;

    localparam int ADDR_SIZE      = 40;             // Virtual address width
    localparam int LINE_ADDR_SIZE = ADDR_SIZE - 4;  // 16-byte lines

    typedef logic [ADDR_SIZE-1:0]      addr_t;
    typedef logic [LINE_ADDR_SIZE-1:0] line_addr_t;  // vaddr[39:4]
    typedef logic [127:0]              icache_line_t; // Four instruction words
    typedef logic [11:0]               icache_idx_t;  // Page offset, vaddr[11:0]
    typedef logic [27:0]               icache_vpn_t;  // Page number, vaddr[39:12]

    // Fetch stage to front end
    typedef struct packed {
        logic  valid;
        addr_t vaddr;
        logic  invalidate_icache; // Flush every line
        logic  invalidate_buffer; // Hold off the cache this cycle
        logic  inval_fetch;       // Kill the outstanding miss
    } req_cpu_icache_t;

    // Front end back to fetch stage
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        instr_page_fault;
    } resp_icache_cpu_t;

    // Line refill request to external memory
    typedef struct packed {
        logic       valid;
        line_addr_t line_addr;
    } mem_req_t;

    // Refill data back from memory
    typedef struct packed {
        logic         valid;
        icache_line_t line;
    } mem_resp_t;

    // Cache controller states
    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0, // Ready, hits served here
        ST_MISS        = 2'd1, // Refill request goes out
        ST_REFILL_WAIT = 2'd2  // Waiting on memory
    } icache_state_t;

    // Config register map
    typedef enum logic {
        CSR_CTRL   = 1'b0,
        CSR_STATUS = 1'b1
    } csr_addr_t;

    typedef struct packed {
        logic en_translation; // Virtual fetch, fault check on
        logic spi_boot;       // Boot from SPI, ROM bypassed
    } frontend_cfg_t;

endpackage
